// ==== hw/ising_pkg.sv ====
////////////////////
// Spin count, weight and field widths, field vector type, run length
////////////////////

`default_nettype none

package ising_pkg;

    localparam int N_SPINS    = 4;
    localparam int SPIN_IDX_W = $clog2(N_SPINS);

    // Signed coupling or bias
    localparam int WEIGHT_W = 8;

    // Signed local field, wide enough for the bias plus N_SPINS-1 couplings
    localparam int FIELD_W = 12;

    // Field of spin k sits in element k
    typedef logic [N_SPINS-1:0][FIELD_W-1:0] field_vec_t;

    // One run is a fixed number of round-robin sweeps
    localparam int SWEEPS     = 2;
    localparam int RUN_CYCLES = SWEEPS * N_SPINS;
    localparam int STEP_W     = $clog2(RUN_CYCLES);

endpackage

`default_nettype wire

// ==== hw/cfg_pkg.sv ====
////////////////////
// Register request struct, address and data widths
////////////////////

`default_nettype none

package cfg_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // Returned when no cell is addressed
    localparam logic [DATA_W-1:0] IDLE_RDATA = 32'hAAAA_AAAA;

    // Spin index sits in the top address bits, row in s_addr and column in d_addr
    typedef struct packed {
        logic              sel;
        logic              wr;
        logic [ADDR_W-1:0] s_addr;
        logic [ADDR_W-1:0] d_addr;
        logic [DATA_W-1:0] wdata;
    } cfg_req_t;

endpackage

`default_nettype wire

// ==== hw/coupled_cell.sv ====
////////////////////
// Off-diagonal cell with one signed coupling
////////////////////

`timescale 1ns/1ps
`default_nettype none

module coupled_cell (
    input  logic                                clk,
    input  logic                                arst_n,
    input  cfg_pkg::cfg_req_t                   cfg,
    input  logic                                spin,
    output logic signed [ising_pkg::FIELD_W-1:0] field_part,
    output logic [cfg_pkg::DATA_W-1:0]          rdata
);

    logic signed [ising_pkg::WEIGHT_W-1:0] weight;
    logic signed [ising_pkg::FIELD_W-1:0]  weight_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            weight <= '0;
        end else if (cfg.sel && cfg.wr) begin
            weight <= cfg.wdata[ising_pkg::WEIGHT_W-1:0];
        end
    end

    assign weight_ext = weight;

    // Spin up adds J, spin down subtracts it
    assign field_part = spin ? weight_ext : -weight_ext;

    assign rdata = cfg.sel ?
        {{(cfg_pkg::DATA_W - ising_pkg::WEIGHT_W){weight[ising_pkg::WEIGHT_W-1]}}, weight} :
        cfg_pkg::IDLE_RDATA;

endmodule

`default_nettype wire

// ==== hw/shorted_cell.sv ====
////////////////////
// Diagonal cell with one spin bias
////////////////////

`timescale 1ns/1ps
`default_nettype none

module shorted_cell (
    input  logic                                clk,
    input  logic                                arst_n,
    input  cfg_pkg::cfg_req_t                   cfg,
    output logic signed [ising_pkg::FIELD_W-1:0] field_part,
    output logic [cfg_pkg::DATA_W-1:0]          rdata
);

    logic signed [ising_pkg::WEIGHT_W-1:0] bias;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bias <= '0;
        end else if (cfg.sel && cfg.wr) begin
            bias <= cfg.wdata[ising_pkg::WEIGHT_W-1:0];
        end
    end

    // Bias enters the row field whatever the spin
    assign field_part = bias;

    assign rdata = cfg.sel ?
        {{(cfg_pkg::DATA_W - ising_pkg::WEIGHT_W){bias[ising_pkg::WEIGHT_W-1]}}, bias} :
        cfg_pkg::IDLE_RDATA;

endmodule

`default_nettype wire

// ==== hw/recursive_matrix.sv ====
////////////////////
// Recursive quadrant split of the coupling matrix
// Address routing, symmetry, row field sums, readback
////////////////////

`timescale 1ns/1ps
`default_nettype none

module recursive_matrix #(
    parameter int N         = 4,
    parameter int DIAGONAL  = 1,
    parameter int TRANSPOSE = 0
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  cfg_pkg::cfg_req_t                   cfg,
    input  logic [N-1:0]                        spins,
    output logic [N-1:0][ising_pkg::FIELD_W-1:0] field,
    output logic [cfg_pkg::DATA_W-1:0]          rdata
);

    if (N != 1) begin : g_split
        // Quadrants 0..3 are upper-left, upper-right, lower-left, lower-right
        logic                                    s_top;
        logic                                    d_top;
        logic                                    upper_right;
        logic                                    lower_left;
        logic                                    mirror;
        logic [3:0]                              qsel;
        cfg_pkg::cfg_req_t                       child_cfg;
        logic [N/2-1:0][ising_pkg::FIELD_W-1:0] part [4];
        logic [cfg_pkg::DATA_W-1:0]              rd [4];

        assign s_top = cfg.s_addr[cfg_pkg::ADDR_W-1];
        assign d_top = cfg.d_addr[cfg_pkg::ADDR_W-1];

        assign upper_right = cfg.sel & ~s_top & d_top;
        assign lower_left  = cfg.sel & s_top & ~d_top;

        assign qsel[0] = cfg.sel & ~s_top & ~d_top;
        assign qsel[3] = cfg.sel & s_top & d_top;

        // A diagonal block stores one off-diagonal quadrant twice, once transposed
        assign qsel[1] = (DIAGONAL != 0)  ? (upper_right | lower_left) :
                         (TRANSPOSE != 0) ? lower_left : upper_right;
        assign qsel[2] = (DIAGONAL != 0)  ? (upper_right | lower_left) :
                         (TRANSPOSE != 0) ? upper_right : lower_left;

        // Lower-left address of a diagonal block is folded onto (d,s)
        assign mirror = (DIAGONAL != 0) && lower_left;

        always_comb begin
            child_cfg = cfg;
            if (mirror) begin
                child_cfg.s_addr = {cfg.d_addr[cfg_pkg::ADDR_W-2:0], 1'b0};
                child_cfg.d_addr = {cfg.s_addr[cfg_pkg::ADDR_W-2:0], 1'b0};
            end else begin
                child_cfg.s_addr = {cfg.s_addr[cfg_pkg::ADDR_W-2:0], 1'b0};
                child_cfg.d_addr = {cfg.d_addr[cfg_pkg::ADDR_W-2:0], 1'b0};
            end
        end

        for (genvar q = 0; q < 4; q++) begin : g_quad
            cfg_pkg::cfg_req_t q_cfg;

            always_comb begin
                q_cfg     = child_cfg;
                q_cfg.sel = qsel[q];
            end

            // Right column quadrants see the high spin indices
            recursive_matrix #(
                .N        (N / 2),
                .DIAGONAL ((q == 0 || q == 3) ? DIAGONAL : 0),
                .TRANSPOSE((q == 2) ? (DIAGONAL | TRANSPOSE) : TRANSPOSE)
            ) i_quad (
                .clk   (clk),
                .arst_n(arst_n),
                .cfg   (q_cfg),
                .spins ((q % 2 == 1) ? spins[N-1:N/2] : spins[N/2-1:0]),
                .field (part[q]),
                .rdata (rd[q])
            );
        end

        for (genvar r = 0; r < N / 2; r++) begin : g_row
            assign field[r]       = part[0][r] + part[1][r];
            assign field[N/2 + r] = part[2][r] + part[3][r];
        end

        always_comb begin
            rdata = cfg_pkg::IDLE_RDATA;
            for (int q = 3; q >= 0; q--) begin
                if (qsel[q]) begin
                    rdata = rd[q];
                end
            end
        end

    end else if (DIAGONAL != 0) begin : g_shorted
        shorted_cell i_shorted (
            .clk       (clk),
            .arst_n    (arst_n),
            .cfg       (cfg),
            .field_part(field[0]),
            .rdata     (rdata)
        );

    end else begin : g_coupled
        coupled_cell i_coupled (
            .clk       (clk),
            .arst_n    (arst_n),
            .cfg       (cfg),
            .spin      (spins[0]),
            .field_part(field[0]),
            .rdata     (rdata)
        );
    end

endmodule

`default_nettype wire

// ==== hw/spin_update.sv ====
////////////////////
// Spin register with round-robin sign-of-field update
////////////////////

`timescale 1ns/1ps
`default_nettype none

module spin_update (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,
    input  logic [ising_pkg::N_SPINS-1:0]   init_spins,
    input  ising_pkg::field_vec_t           field,
    output logic [ising_pkg::N_SPINS-1:0]   spins,
    output logic                            busy,
    output logic                            done
);

    logic [ising_pkg::STEP_W-1:0]        step;
    logic [ising_pkg::SPIN_IDX_W-1:0]    idx;
    logic signed [ising_pkg::FIELD_W-1:0] cur_field;

    // Spin step mod N_SPINS is visited this cycle
    assign idx       = step[ising_pkg::SPIN_IDX_W-1:0];
    assign cur_field = field[idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            spins <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
            step  <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (start) begin
                    spins <= init_spins;
                    busy  <= 1'b1;
                    step  <= '0;
                end
            end else begin
                // Zero field leaves the spin as it is
                if (cur_field > 0) begin
                    spins[idx] <= 1'b1;
                end else if (cur_field < 0) begin
                    spins[idx] <= 1'b0;
                end
                step <= step + 1'b1;
                if (step == ising_pkg::STEP_W'(ising_pkg::RUN_CYCLES - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/ising_core.sv ====
////////////////////
// Ising solver top, matrix and update stage
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ising_core (
    input  logic                          clk,
    input  logic                          arst_n,
    input  cfg_pkg::cfg_req_t             cfg,
    input  logic                          start,
    input  logic [ising_pkg::N_SPINS-1:0] init_spins,
    output logic [cfg_pkg::DATA_W-1:0]    rdata,
    output logic [ising_pkg::N_SPINS-1:0] spins,
    output logic                          busy,
    output logic                          done
);

    // Bit k of spins and element k of field belong to spin k
    ising_pkg::field_vec_t field;

    recursive_matrix #(
        .N        (ising_pkg::N_SPINS),
        .DIAGONAL (1),
        .TRANSPOSE(0)
    ) i_matrix (
        .clk   (clk),
        .arst_n(arst_n),
        .cfg   (cfg),
        .spins (spins),
        .field (field),
        .rdata (rdata)
    );

    spin_update i_spin_update (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .init_spins(init_spins),
        .field     (field),
        .spins     (spins),
        .busy      (busy),
        .done      (done)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
////////////////////
// Testbench clock and reset generator
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, like the other inputs
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verif/ising_core_assert.sv ====
////////////////////
// Concurrent assertions on the update control, bound to spin_update
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ising_core_assert (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          start,
    input logic                          busy,
    input logic                          done,
    input logic [ising_pkg::N_SPINS-1:0] spins
);

    int fail_count = 0;

    done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_count++;
        end

    done_with_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
        done == $fell(busy))
        else begin
            $error("done and the falling edge of busy are not aligned");
            fail_count++;
        end

    // Spins move only on an update step or on the start edge
    spins_only_when_running: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(spins) |-> ($past(busy) || $past(start)))
        else begin
            $error("spins changed outside a run");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk) !arst_n |-> (!busy && !done))
        else begin
            $error("busy or done high during reset");
            fail_count++;
        end

endmodule

bind spin_update ising_core_assert i_ising_core_assert (
    .clk   (clk),
    .arst_n(arst_n),
    .start (start),
    .busy  (busy),
    .done  (done),
    .spins (spins)
);

`default_nettype wire

// ==== verif/ising_core_tb.sv ====
////////////////////
// Directed tests of the Ising core against a reference model
////////////////////

`timescale 1ns/1ps
`default_nettype none

module ising_core_tb;

    localparam int N        = ising_pkg::N_SPINS;
    localparam int RUN      = ising_pkg::RUN_CYCLES;
    localparam int WEIGHT_W = ising_pkg::WEIGHT_W;
    localparam int ADDR_W   = cfg_pkg::ADDR_W;
    localparam int DATA_W   = cfg_pkg::DATA_W;
    localparam int LOW_W    = ADDR_W - ising_pkg::SPIN_IDX_W;
    localparam int PAD_W    = DATA_W - WEIGHT_W;
    localparam int RUNS     = 6;

    // Cycles per job cover matrix programming, one run and some slack
    localparam int JOB_CYCLES   = N * (N + 1) / 2 + RUN + 4;
    localparam int LIMIT_CYCLES = 10 + 6 * N * N + 20 + (RUNS + 3) * JOB_CYCLES + 100;

    logic              clk;
    logic              arst_n;
    cfg_pkg::cfg_req_t cfg;
    logic              start;
    logic [N-1:0]      init_spins;
    logic [DATA_W-1:0] rdata;
    logic [N-1:0]      spins;
    logic              busy;
    logic              done;

    // Model matrix with the biases on its diagonal
    logic signed [WEIGHT_W-1:0] w_ref [N][N];
    logic [N-1:0]               traj [RUN+1];

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .arst_n(arst_n)
    );

    ising_core i_ising_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .start     (start),
        .init_spins(init_spins),
        .rdata     (rdata),
        .spins     (spins),
        .busy      (busy),
        .done      (done)
    );

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [ADDR_W-1:0] spin_addr(input int idx);
        return {ising_pkg::SPIN_IDX_W'(idx), LOW_W'($urandom)};
    endfunction

    function automatic logic [DATA_W-1:0] sign_extend(input logic [WEIGHT_W-1:0] v);
        return DATA_W'(int'($signed(v)));
    endfunction

    task automatic write_cell(input int s, input int d, input logic [WEIGHT_W-1:0] v);
        cfg.sel    = 1'b1;
        cfg.wr     = 1'b1;
        cfg.s_addr = spin_addr(s);
        cfg.d_addr = spin_addr(d);
        cfg.wdata  = {PAD_W'($urandom), v};
        next_cycle();
        cfg.sel     = 1'b0;
        cfg.wr      = 1'b0;
        w_ref[s][d] = v;
        w_ref[d][s] = v;
    endtask

    task automatic read_all();
        for (int s = 0; s < N; s++) begin
            for (int d = 0; d < N; d++) begin
                cfg.sel    = 1'b1;
                cfg.wr     = 1'b0;
                cfg.s_addr = spin_addr(s);
                cfg.d_addr = spin_addr(d);
                cfg.wdata  = $urandom;
                #2;
                check_equal($sformatf("rdata(%0d,%0d)", s, d), rdata, sign_extend(w_ref[s][d]));
                next_cycle();
                cfg.sel = 1'b0;
            end
        end
    endtask

    task automatic program_random();
        for (int s = 0; s < N; s++) begin
            for (int d = s; d < N; d++) begin
                write_cell(s, d, WEIGHT_W'($urandom));
            end
        end
    endtask

    // Replays the sequential sign-of-field rule into traj
    // traj[k] holds the spins after step k
    task automatic model_replay(input logic [N-1:0] init);
        logic [N-1:0] s;
        int           k;
        int           f;
        int           wkj;
        s       = init;
        traj[0] = s;
        for (int step = 0; step < RUN; step++) begin
            k = step % N;
            f = int'(w_ref[k][k]);
            for (int j = 0; j < N; j++) begin
                if (j != k) begin
                    wkj = int'(w_ref[k][j]);
                    f   = f + (s[j] ? wkj : -wkj);
                end
            end
            if (f > 0) begin
                s[k] = 1'b1;
            end else if (f < 0) begin
                s[k] = 1'b0;
            end
            traj[step+1] = s;
        end
    endtask

    // A second start pulse lands at edge pulse_at of the run
    // pulse_at of 0 means no second pulse
    task automatic run_job(input logic [N-1:0] init, input int pulse_at);
        int edges;
        model_replay(init);
        start      = 1'b1;
        init_spins = init;
        edges      = 0;
        do begin
            next_cycle();
            edges++;
            start      = (edges == pulse_at);
            init_spins = ~init;
            if (edges > RUN + 1) begin
                $display("Error: done did not rise at the end of the run");
                $display("Simulation failed");
                $fatal(1, "missing done");
            end
            check_equal("spins", 32'(spins), 32'(traj[edges-1]));
            check_equal("busy", 32'(busy), 32'(edges <= RUN));
        end while (!done);
        check_equal("edges to done", edges, RUN + 1);
    endtask

    task automatic reset_state();
        check_equal("busy", 32'(busy), 0);
        check_equal("done", 32'(done), 0);
        check_equal("spins", 32'(spins), 0);
        check_equal("rdata idle", rdata, cfg_pkg::IDLE_RDATA);
        read_all();
    endtask

    task automatic readback_cells();
        program_random();
        read_all();
        // Rewrite each coupling through its mirrored address
        for (int s = 0; s < N; s++) begin
            for (int d = s + 1; d < N; d++) begin
                write_cell(d, s, WEIGHT_W'($urandom));
            end
        end
        read_all();
    endtask

    task automatic idle_reads();
        repeat (20) begin
            cfg.sel    = 1'b0;
            cfg.wr     = 1'($urandom);
            cfg.s_addr = ADDR_W'($urandom);
            cfg.d_addr = ADDR_W'($urandom);
            cfg.wdata  = $urandom;
            #2;
            check_equal("rdata idle", rdata, cfg_pkg::IDLE_RDATA);
            next_cycle();
        end
        cfg.wr = 1'b0;
        read_all();
    endtask

    task automatic ferro_anneal();
        write_cell(0, 0, 8'd10);
        write_cell(1, 1, 8'd0);
        write_cell(2, 2, 8'd0);
        write_cell(3, 3, 8'd0);
        write_cell(0, 1, 8'd12);
        write_cell(0, 2, 8'd7);
        write_cell(0, 3, 8'd9);
        write_cell(1, 2, 8'd5);
        write_cell(1, 3, 8'd11);
        write_cell(2, 3, 8'd6);
        run_job(4'b0110, 0);
        check_equal("spins after anneal", 32'(spins), 32'hF);
    endtask

    task automatic random_runs();
        repeat (RUNS) begin
            program_random();
            run_job(N'($urandom), 0);
        end
    endtask

    task automatic start_while_busy();
        program_random();
        run_job(N'($urandom), 1);
        run_job(N'($urandom), 5);
    endtask

    initial begin
        cfg        = '0;
        start      = 1'b0;
        init_spins = '0;
        void'($urandom(61242));
        for (int s = 0; s < N; s++) begin
            for (int d = 0; d < N; d++) begin
                w_ref[s][d] = '0;
            end
        end
        wait (arst_n === 1'b1);
        next_cycle();
        reset_state();
        readback_cells();
        idle_reads();
        ferro_anneal();
        random_runs();
        start_while_busy();
        next_cycle();
        if (i_ising_core.i_spin_update.i_ising_core_assert.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Error: bound assertions failed during the run");
            $display("Simulation failed");
            $fatal(1, "assertion failures");
        end
    end

    // Stop at the first failure of a bound assertion
    initial begin
        wait (i_ising_core.i_spin_update.i_ising_core_assert.fail_count != 0);
        $display("Error: a bound assertion on the update control failed");
        $display("Simulation failed");
        $fatal(1, "assertion failure");
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d cycles", LIMIT_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/ising_pkg.sv
hw/cfg_pkg.sv
hw/coupled_cell.sv
hw/shorted_cell.sv
hw/recursive_matrix.sv
hw/spin_update.sv
hw/ising_core.sv
verif/tb_clock_gen.sv
verif/ising_core_assert.sv
verif/ising_core_tb.sv

// ==== Bender.yml ====
package:
  name: ising_core

sources:
  - hw/ising_pkg.sv
  - hw/cfg_pkg.sv
  - hw/coupled_cell.sv
  - hw/shorted_cell.sv
  - hw/recursive_matrix.sv
  - hw/spin_update.sv
  - hw/ising_core.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/ising_core_assert.sv
      - verif/ising_core_tb.sv
